/* byte_fifo_top.f */
+incdir+hdl
hdl/byte_fifo_pkg.sv
hdl/ram_2p.sv
hdl/ram_2p_asym.sv
hdl/byte_fifo_ctrl.sv
hdl/fifo_apb_regs.sv
hdl/byte_fifo_top.sv
testbench/tb_clkgen.sv
testbench/byte_fifo_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= byte_fifo_tb
FILELIST ?= byte_fifo_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps
PASS_MSG := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/byte_fifo_tb.sv */
`include "byte_fifo_settings.svh"

module byte_fifo_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DRIVE_NS = 2;
   localparam int DEPTH = 1 << `BF_RADDR_W;
   localparam int WORD_BYTES = `BF_WORD_W / `BF_BYTE_W;
   localparam int WAIT_LIMIT = 200;

   logic clk;
   logic reset;
   logic push;
   byte_fifo_pkg::word_t push_data;
   logic full;
   logic pop;
   byte_fifo_pkg::byte_t pop_data;
   logic pop_valid;
   logic empty;
   logic psel;
   logic penable;
   logic pwrite;
   logic [`BF_PADDR_W-1:0] paddr;
   byte_fifo_pkg::apb_data_t pwdata;
   byte_fifo_pkg::apb_data_t prdata;
   logic pready;
   logic pslverr;

   logic [31:0] lfsr_state;
   // bytes held in the FIFO and bytes popped but not yet seen
   byte_fifo_pkg::byte_t model_q[$];
   byte_fifo_pkg::byte_t expect_q[$];
   logic pop_accept;
   logic checking;
   logic timed_out;
   int exp_ovf;
   int exp_unf;
   int errors;
   int timeouts;

   tb_clkgen #(
      .PERIOD_NS(20),
      .RESET_CYCLES(5),
      .DRIVE_NS(DRIVE_NS)
   ) i_clkgen (
      .clk  (clk),
      .reset(reset)
   );

   byte_fifo_top i_byte_fifo_top (
      .clk      (clk),
      .reset    (reset),
      .push     (push),
      .push_data(push_data),
      .full     (full),
      .pop      (pop),
      .pop_data (pop_data),
      .pop_valid(pop_valid),
      .empty    (empty),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr)
   );

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h80200003;
      end
      return state >> 1;
   endfunction

   function automatic logic random_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic byte_fifo_pkg::word_t random_word();
      byte_fifo_pkg::word_t w;
      w = '0;
      for (int i = 0; i < `BF_WORD_W; i++) begin
         w = {w[`BF_WORD_W-2:0], random_bit()};
      end
      return w;
   endfunction

   // full once a whole word no longer fits
   function automatic logic expected_full(input int count);
      return (DEPTH - count) < WORD_BYTES;
   endfunction

   function automatic logic expected_empty(input int count);
      return count == 0;
   endfunction

   function automatic byte_fifo_pkg::apb_data_t expected_status(input int count);
      byte_fifo_pkg::apb_data_t s;
      s = '0;
      s[6:0] = count[6:0];
      s[8] = expected_full(count);
      s[9] = expected_empty(count);
      return s;
   endfunction

   task automatic check_byte(input string name, input byte_fifo_pkg::byte_t got,
                             input byte_fifo_pkg::byte_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_level(input string name, input byte_fifo_pkg::level_t got,
                              input byte_fifo_pkg::level_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_reg(input string name, input byte_fifo_pkg::apb_data_t got,
                            input byte_fifo_pkg::apb_data_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic timeout_hit(input string what);
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: %s at %0t", what, $time);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_NS;
   endtask

   // drive one cycle of push and pop and move the model to match
   task automatic apply(input logic do_push, input byte_fifo_pkg::word_t word,
                        input logic do_pop);
      int count;
      count = model_q.size();
      push = do_push;
      push_data = word;
      pop = do_pop;
      pop_accept = 1'b0;
      if (do_pop) begin
         if (count > 0) begin
            expect_q.push_back(model_q.pop_front());
            pop_accept = 1'b1;
         end else if (exp_unf < 255) begin
            exp_unf++;
         end
      end
      if (do_push) begin
         if (expected_full(count)) begin
            if (exp_ovf < 255) begin
               exp_ovf++;
            end
         end else begin
            for (int b = 0; b < WORD_BYTES; b++) begin
               model_q.push_back(word[b*`BF_BYTE_W +: `BF_BYTE_W]);
            end
         end
      end
   endtask

   task automatic apb_access(input logic write, input logic [`BF_PADDR_W-1:0] addr,
                             input byte_fifo_pkg::apb_data_t wdata,
                             output byte_fifo_pkg::apb_data_t rdata, output logic err);
      next_cycle();
      psel = 1'b1;
      penable = 1'b0;
      pwrite = write;
      paddr = addr;
      pwdata = wdata;
      next_cycle();
      penable = 1'b1;
      // flush lands on the edge that closes this access
      if (write && addr == `BF_REG_CTRL && wdata[0]) begin
         model_q.delete();
         exp_ovf = 0;
         exp_unf = 0;
      end
      @(negedge clk);
      rdata = prdata;
      err = pslverr;
      check_flag("pready", pready, 1'b1);
      next_cycle();
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic read_reg(input string name, input logic [`BF_PADDR_W-1:0] addr,
                           input byte_fifo_pkg::apb_data_t exp);
      byte_fifo_pkg::apb_data_t rd;
      logic err;
      apb_access(1'b0, addr, '0, rd, err);
      check_flag("pslverr", err, 1'b0);
      check_reg(name, rd, exp);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (expect_q.size() > 0 && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (expect_q.size() > 0) begin
         timeout_hit($sformatf("%0d popped bytes never appeared", expect_q.size()));
      end
   endtask

   task automatic test_byte_order();
      next_cycle();
      apply(1'b1, 32'h44332211, 1'b0);
      next_cycle();
      apply(1'b1, 32'h88776655, 1'b0);
      for (int i = 0; i < 2 * WORD_BYTES; i++) begin
         next_cycle();
         apply(1'b0, '0, 1'b1);
      end
      next_cycle();
      apply(1'b0, '0, 1'b0);
      wait_drained();
   endtask

   task automatic test_fill_overflow();
      byte_fifo_pkg::apb_data_t rd;
      logic err;
      int n;
      n = 0;
      next_cycle();
      while (!full && n < DEPTH) begin
         apply(1'b1, random_word(), 1'b0);
         next_cycle();
         n++;
      end
      apply(1'b0, '0, 1'b0);
      if (!full) begin
         timeout_hit("full never rose while filling");
         return;
      end
      apb_access(1'b0, `BF_REG_STATUS, '0, rd, err);
      check_flag("pslverr", err, 1'b0);
      check_level("status level", byte_fifo_pkg::level_t'(rd[6:0]),
                  byte_fifo_pkg::level_t'(DEPTH));
      check_flag("status full", rd[8], 1'b1);
      check_reg("status", rd, expected_status(model_q.size()));
      repeat (3) begin
         next_cycle();
         apply(1'b1, random_word(), 1'b0);
      end
      next_cycle();
      apply(1'b0, '0, 1'b0);
      read_reg("ovf", `BF_REG_OVF, exp_ovf);
   endtask

   task automatic test_drain_underflow();
      int n;
      n = 0;
      next_cycle();
      while (!empty && n < DEPTH + WORD_BYTES) begin
         apply(1'b0, '0, 1'b1);
         next_cycle();
         n++;
      end
      apply(1'b0, '0, 1'b0);
      if (!empty) begin
         timeout_hit("empty never rose while draining");
         return;
      end
      check_level("bytes drained", byte_fifo_pkg::level_t'(n), byte_fifo_pkg::level_t'(DEPTH));
      wait_drained();
      // level and empty as seen through the register block
      read_reg("status", `BF_REG_STATUS, expected_status(0));
      repeat (2) begin
         next_cycle();
         apply(1'b0, '0, 1'b1);
      end
      next_cycle();
      apply(1'b0, '0, 1'b0);
      read_reg("unf", `BF_REG_UNF, exp_unf);
   endtask

   task automatic test_wrap();
      logic do_push;
      logic do_pop;
      for (int i = 0; i < 300; i++) begin
         next_cycle();
         do_push = random_bit() && !full;
         do_pop = random_bit() && !empty;
         apply(do_push, random_word(), do_pop);
      end
      next_cycle();
      apply(1'b0, '0, 1'b0);
      wait_drained();
   endtask

   task automatic test_apb_control();
      byte_fifo_pkg::apb_data_t rd;
      logic err;
      // make sure there is something to flush
      next_cycle();
      apply(1'b1, random_word(), 1'b0);
      next_cycle();
      apply(1'b0, '0, 1'b0);
      apb_access(1'b1, `BF_REG_CTRL, 32'h1, rd, err);
      check_flag("pslverr", err, 1'b0);
      check_flag("empty", empty, 1'b1);
      read_reg("status", `BF_REG_STATUS, expected_status(0));
      read_reg("ovf", `BF_REG_OVF, exp_ovf);
      read_reg("unf", `BF_REG_UNF, exp_unf);
      apb_access(1'b0, 8'h10, '0, rd, err);
      check_flag("pslverr", err, 1'b1);
   endtask

   task automatic run_tests();
      test_byte_order();
      if (timed_out) return;
      test_fill_overflow();
      if (timed_out) return;
      test_drain_underflow();
      if (timed_out) return;
      test_wrap();
      if (timed_out) return;
      test_apb_control();
   endtask

   task automatic finish_run();
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   // flags follow the model count and bytes follow the popped queue
   initial begin
      logic exp_valid;
      int exp_count;
      exp_valid = 1'b0;
      exp_count = 0;
      forever begin
         @(posedge clk);
         exp_valid = pop_accept;
         exp_count = model_q.size();
         @(negedge clk);
         if (checking) begin
            check_flag("pop_valid", pop_valid, exp_valid);
            check_flag("full", full, expected_full(exp_count));
            check_flag("empty", empty, expected_empty(exp_count));
            if (pop_valid === 1'b1 && expect_q.size() == 0) begin
               errors++;
               $display("pop_valid rose with no byte outstanding at %0t", $time);
            end else if (pop_valid === 1'b1) begin
               check_byte("pop_data", pop_data, expect_q.pop_front());
            end
         end
      end
   end

   initial begin
      int n;
      push = 1'b0;
      push_data = '0;
      pop = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      lfsr_state = 32'h13e305d8;
      pop_accept = 1'b0;
      checking = 1'b0;
      timed_out = 1'b0;
      exp_ovf = 0;
      exp_unf = 0;
      errors = 0;
      timeouts = 0;
      n = 0;
      @(negedge clk);
      while (reset !== 1'b0 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (reset !== 1'b0) begin
         timeout_hit("reset never released");
      end else begin
         check_flag("empty", empty, 1'b1);
         check_flag("full", full, 1'b0);
         check_flag("pop_valid", pop_valid, 1'b0);
         check_flag("pslverr", pslverr, 1'b0);
         next_cycle();
         checking = 1'b1;
         run_tests();
      end
      finish_run();
   end

endmodule

/* testbench/tb_clkgen.sv */
module tb_clkgen #(
   parameter int PERIOD_NS = 20,
   parameter int RESET_CYCLES = 5,
   parameter int DRIVE_NS = 2
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release lines up with the other driven inputs
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_NS;
      reset = 1'b0;
   end

endmodule

/* hdl/byte_fifo_top.sv */
`include "byte_fifo_settings.svh"

module byte_fifo_top (
   input  logic                      clk,
   input  logic                      reset,
   // push side
   input  logic                      push,
   input  byte_fifo_pkg::word_t      push_data,
   output logic                      full,
   // pop side
   input  logic                      pop,
   output byte_fifo_pkg::byte_t      pop_data,
   output logic                      pop_valid,
   output logic                      empty,
   // APB status and control
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [`BF_PADDR_W-1:0]    paddr,
   input  byte_fifo_pkg::apb_data_t  pwdata,
   output byte_fifo_pkg::apb_data_t  prdata,
   output logic                      pready,
   output logic                      pslverr
);

   ram_port_if #(
      .W_DATA_W(`BF_WORD_W),
      .R_DATA_W(`BF_BYTE_W),
      .W_ADDR_W(byte_fifo_pkg::WADDR_W),
      .R_ADDR_W(`BF_RADDR_W)
   ) ram_bus ();

   fifo_stat_if stat_bus ();

   // words in, bytes out
   ram_2p_asym #(
      .W_DATA_W(`BF_WORD_W),
      .R_DATA_W(`BF_BYTE_W),
      .ADDR_W  (`BF_RADDR_W)
   ) i_ram (
      .clk(clk),
      .ram(ram_bus.ram)
   );

   byte_fifo_ctrl i_ctrl (
      .clk      (clk),
      .reset    (reset),
      .push     (push),
      .push_data(push_data),
      .pop      (pop),
      .pop_valid(pop_valid),
      .ram      (ram_bus.ctrl),
      .stat     (stat_bus.ctrl)
   );

   fifo_apb_regs i_regs (
      .clk    (clk),
      .reset  (reset),
      .psel   (psel),
      .penable(penable),
      .pwrite (pwrite),
      .paddr  (paddr),
      .pwdata (pwdata),
      .prdata (prdata),
      .pready (pready),
      .pslverr(pslverr),
      .stat   (stat_bus.regs)
   );

   assign pop_data = ram_bus.r_data;
   assign full = stat_bus.full;
   assign empty = stat_bus.empty;

endmodule

/* hdl/fifo_apb_regs.sv */
`include "byte_fifo_settings.svh"

module fifo_apb_regs (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [`BF_PADDR_W-1:0]    paddr,
   input  byte_fifo_pkg::apb_data_t  pwdata,
   output byte_fifo_pkg::apb_data_t  prdata,
   output logic                      pready,
   output logic                      pslverr,
   fifo_stat_if.regs                 stat
);

   byte_fifo_pkg::cnt_t ovf_cnt;
   byte_fifo_pkg::cnt_t unf_cnt;
   logic access;
   logic mapped;

   assign access = psel && penable;
   assign mapped = (paddr == `BF_REG_STATUS) || (paddr == `BF_REG_OVF) ||
                   (paddr == `BF_REG_UNF) || (paddr == `BF_REG_CTRL);

   // no wait states
   assign pready = 1'b1;
   assign pslverr = access && !mapped;

   always_comb begin
      prdata = '0;
      case (paddr)
         `BF_REG_STATUS: begin
            prdata[6:0] = stat.level;
            prdata[8] = stat.full;
            prdata[9] = stat.empty;
         end
         `BF_REG_OVF: prdata[7:0] = ovf_cnt;
         `BF_REG_UNF: prdata[7:0] = unf_cnt;
         default: prdata = '0;
      endcase
   end

   // flush pulse, applied by the controller at the end of the access
   assign stat.flush = access && pwrite && (paddr == `BF_REG_CTRL) && pwdata[0];

   // counters stick at all ones
   always_ff @(posedge clk) begin
      if (reset || stat.flush) begin
         ovf_cnt <= '0;
         unf_cnt <= '0;
      end else begin
         if (stat.overflow && ovf_cnt != '1) begin
            ovf_cnt <= ovf_cnt + 1'b1;
         end
         if (stat.underflow && unf_cnt != '1) begin
            unf_cnt <= unf_cnt + 1'b1;
         end
      end
   end

   a_penable_psel: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
      else $error("fifo_apb_regs: penable without psel");

endmodule

/* hdl/byte_fifo_ctrl.sv */
`include "byte_fifo_settings.svh"

module byte_fifo_ctrl (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  byte_fifo_pkg::word_t  push_data,
   input  logic                  pop,
   output logic                  pop_valid,
   ram_port_if.ctrl              ram,
   fifo_stat_if.ctrl             stat
);

   localparam int DEPTH = 1 << `BF_RADDR_W;
   localparam int BYTE_SEL_W = $clog2(byte_fifo_pkg::WORD_BYTES);

   byte_fifo_pkg::wptr_t wptr;
   byte_fifo_pkg::rptr_t rptr;
   byte_fifo_pkg::level_t level;
   logic full;
   logic empty;
   logic push_ok;
   logic pop_ok;

   // word pointer scaled to bytes, wrap bits keep the difference exact
   assign level = {wptr, {BYTE_SEL_W{1'b0}}} - rptr;

   // full once a whole word no longer fits
   assign full = level > byte_fifo_pkg::level_t'(DEPTH - byte_fifo_pkg::WORD_BYTES);
   assign empty = level == '0;

   assign push_ok = push && !full;
   assign pop_ok = pop && !empty;

   always_ff @(posedge clk) begin
      if (reset || stat.flush) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (push_ok) begin
            wptr <= wptr + 1'b1;
         end
         if (pop_ok) begin
            rptr <= rptr + 1'b1;
         end
      end
   end

   // data leaves the RAM one cycle after the read
   always_ff @(posedge clk) begin
      if (reset) begin
         pop_valid <= 1'b0;
         stat.overflow <= 1'b0;
         stat.underflow <= 1'b0;
      end else begin
         pop_valid <= pop_ok;
         stat.overflow <= push && full;
         stat.underflow <= pop && empty;
      end
   end

   assign ram.w_en = push_ok;
   assign ram.w_addr = wptr[byte_fifo_pkg::WADDR_W-1:0];
   assign ram.w_data = push_data;
   assign ram.r_en = pop_ok;
   assign ram.r_addr = rptr[`BF_RADDR_W-1:0];

   assign stat.level = level;
   assign stat.full = full;
   assign stat.empty = empty;

   a_full_empty: assert property (@(posedge clk) disable iff (reset) !(full && empty))
      else $error("byte_fifo_ctrl: full and empty together");

   a_level_max: assert property (@(posedge clk) disable iff (reset)
      level <= byte_fifo_pkg::level_t'(DEPTH))
      else $error("byte_fifo_ctrl: level %0d above depth", level);

endmodule

/* hdl/ram_2p_asym.sv */
module ram_2p_asym #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   // address width of the narrow side
   parameter int ADDR_W = 6
) (
   input logic clk,
   ram_port_if.ram ram
);

   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int N = MAXDATA_W / MINDATA_W;
   localparam int LSB_W = $clog2(N);
   // every block is addressed like the wide side
   localparam int MINADDR_W = ADDR_W - LSB_W;
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   logic [N-1:0] en_wr;
   logic [MINADDR_W-1:0] addr_wr [N];
   logic [MINDATA_W-1:0] data_wr [N];
   logic [MINADDR_W-1:0] addr_rd [N];
   logic [MINDATA_W-1:0] data_rd [N];

   for (genvar g = 0; g < N; g++) begin : g_blk
      ram_2p #(
         .DATA_W(MINDATA_W),
         .ADDR_W(MINADDR_W)
      ) i_ram (
         .clk   (clk),
         .w_en  (en_wr[g]),
         .w_addr(addr_wr[g]),
         .w_data(data_wr[g]),
         .r_en  (ram.r_en),
         .r_addr(addr_rd[g]),
         .r_data(data_rd[g])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_wr
      logic [LSB_W-1:0] sel_q;

      // each block takes its slice of the word
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j] = ram.w_en;
            addr_wr[j] = ram.w_addr;
            data_wr[j] = ram.w_data[j*MINDATA_W +: MINDATA_W];
            addr_rd[j] = ram.r_addr[R_ADDR_W-1 -: MINADDR_W];
         end
      end

      // block select follows the registered read
      always_ff @(posedge clk) begin
         if (ram.r_en) begin
            sel_q <= ram.r_addr[LSB_W-1:0];
         end
      end

      assign ram.r_data = data_rd[sel_q];

   end else if (W_DATA_W < R_DATA_W) begin : g_wide_rd
      // low write address bits pick a single block
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j] = ram.w_en && (ram.w_addr[LSB_W-1:0] == LSB_W'(j));
            addr_wr[j] = ram.w_addr[W_ADDR_W-1 -: MINADDR_W];
            data_wr[j] = ram.w_data;
            addr_rd[j] = ram.r_addr;
         end
      end

      always_comb begin
         for (int k = 0; k < N; k++) begin
            ram.r_data[k*MINDATA_W +: MINDATA_W] = data_rd[k];
         end
      end

   end else begin : g_equal
      always_comb begin
         en_wr[0] = ram.w_en;
         addr_wr[0] = ram.w_addr;
         data_wr[0] = ram.w_data;
         addr_rd[0] = ram.r_addr;
      end

      assign ram.r_data = data_rd[0];
   end

   a_width_ratio: assert property (@(posedge clk) (MAXDATA_W % MINDATA_W) == 0)
      else $error("ram_2p_asym: widths %0d and %0d do not divide", W_DATA_W, R_DATA_W);

endmodule

/* hdl/ram_2p.sv */
module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // read-before-write on an address collision
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

/* hdl/byte_fifo_pkg.sv */
`include "byte_fifo_settings.svh"

package byte_fifo_pkg;

   localparam int WORD_BYTES = `BF_WORD_W / `BF_BYTE_W;
   // word address width on the push side
   localparam int WADDR_W = `BF_RADDR_W - $clog2(WORD_BYTES);

   typedef logic [`BF_WORD_W-1:0] word_t;
   typedef logic [`BF_BYTE_W-1:0] byte_t;

   // pointers carry one extra wrap bit
   typedef logic [WADDR_W:0] wptr_t;
   typedef logic [`BF_RADDR_W:0] rptr_t;

   typedef logic [`BF_RADDR_W:0] level_t;
   typedef logic [7:0] cnt_t;
   typedef logic [31:0] apb_data_t;

endpackage

// request side of the storage, generic over both widths
interface ram_port_if #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int W_ADDR_W = 4,
   parameter int R_ADDR_W = 6
);
   logic w_en;
   logic [W_ADDR_W-1:0] w_addr;
   logic [W_DATA_W-1:0] w_data;
   logic r_en;
   logic [R_ADDR_W-1:0] r_addr;
   logic [R_DATA_W-1:0] r_data;

   modport ctrl (output w_en, w_addr, w_data, r_en, r_addr, input r_data);
   modport ram (input w_en, w_addr, w_data, r_en, r_addr, output r_data);
endinterface

// status toward the register block, flush back to the controller
interface fifo_stat_if;
   byte_fifo_pkg::level_t level;
   logic full;
   logic empty;
   logic overflow;
   logic underflow;
   logic flush;

   modport ctrl (output level, full, empty, overflow, underflow, input flush);
   modport regs (input level, full, empty, overflow, underflow, output flush);
endinterface

/* hdl/byte_fifo_settings.svh */
`ifndef BYTE_FIFO_SETTINGS_SVH
`define BYTE_FIFO_SETTINGS_SVH

// data path widths
`define BF_WORD_W 32
`define BF_BYTE_W 8

// byte address width, 64 bytes of storage
`define BF_RADDR_W 6

// APB address width and register offsets
`define BF_PADDR_W 8
`define BF_REG_STATUS 8'h00
`define BF_REG_OVF 8'h04
`define BF_REG_UNF 8'h08
`define BF_REG_CTRL 8'h0C

`endif
